// ==== logic/vst_defines.svh ====
`ifndef VST_DEFINES_SVH
`define VST_DEFINES_SVH

// Lane count, each lane hands over one element word per operand
`define VST_NR_LANES 2

// Bits per lane operand
`define VST_ELEN 64

// AXI data and address widths
`define VST_AXI_DATA_W 64
`define VST_AXI_ADDR_W 32

// In-flight store instructions in the store unit
`define VST_QUEUE_DEPTH 4

// Size of the instruction id space
`define VST_NR_VINSN 8

// Longest AW burst in beats
`define VST_MAX_BEATS 4

`endif

// ==== logic/vst_pkg.sv ====
`include "vst_defines.svh"

package vst_pkg;

  ////////////////////////////////////////////////////
  // Basic scalar types

  // Element width of a store, log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Instruction id, one bit per id in the running map
  typedef logic [$clog2(`VST_NR_VINSN)-1:0] vinsn_id_t;

  // Vector length in elements
  typedef logic [15:0] vl_t;

  // Byte count of one instruction, vl scaled by up to eight bytes
  typedef logic [$bits(vl_t)+2:0] bcnt_t;

  ////////////////////////////////////////////////////
  // Sequencer request and response

  typedef struct packed {
    vinsn_id_t                   id;
    logic [`VST_AXI_ADDR_W-1:0] addr;
    vl_t                         vl;
    vew_e                        vsew;
    // Set means unmasked
    logic                        vm;
  } st_req_t;

  typedef struct packed {
    logic [`VST_NR_VINSN-1:0] vinsn_done;
  } st_resp_t;

endpackage : vst_pkg

// ==== logic/vst_insn_if.sv ====
`timescale 1ns/10ps

// Issue-phase instruction from the store unit to the address generator
interface vst_insn_if;

  logic              valid;
  logic              ready;
  vst_pkg::st_req_t  req;
  // Total bytes of the store, vl scaled by element width
  vst_pkg::bcnt_t    byte_cnt;

  // Store unit side
  modport issuer (
    output valid,
    output req,
    output byte_cnt,
    input  ready
  );

  // Address generator side
  modport taker (
    input  valid,
    input  req,
    input  byte_cnt,
    output ready
  );

endinterface : vst_insn_if

// ==== logic/vst_burst_if.sv ====
`timescale 1ns/10ps
`include "vst_defines.svh"

// One posted write burst, AW already sent
interface vst_burst_if;

  logic                       valid;
  logic                       ready;
  logic [`VST_AXI_ADDR_W-1:0] addr;
  // Beats minus one, AXI style
  logic [7:0]                 len;

  modport source (
    output valid,
    output addr,
    output len,
    input  ready
  );

  modport sink (
    input  valid,
    input  addr,
    input  len,
    output ready
  );

endinterface : vst_burst_if

// ==== logic/vst_addrgen.sv ====
`timescale 1ns/10ps
`include "vst_defines.svh"

module vst_addrgen (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  vst_insn_if.taker                  insn,
  vst_burst_if.source                burst,
  output logic [`VST_AXI_ADDR_W-1:0] axi_aw_addr_o,
  output logic [7:0]                 axi_aw_len_o,
  output logic [2:0]                 axi_aw_size_o,
  output logic [1:0]                 axi_aw_burst_o,
  output logic                       axi_aw_valid_o,
  input  logic                       axi_aw_ready_i
);

  localparam int unsigned AxiBytes = `VST_AXI_DATA_W / 8;
  localparam int unsigned AxiShift = $clog2(AxiBytes);
  localparam int unsigned MaxBeats = `VST_MAX_BEATS;

  ////////////////////////////////////////////////////
  // Burst splitting

  logic                       aw_pend_q;
  logic [`VST_AXI_ADDR_W-1:0] aw_addr_q;
  logic [7:0]                 aw_len_q;
  // Beats still to be covered by later bursts
  vst_pkg::bcnt_t             rem_q;
  logic [`VST_AXI_ADDR_W-1:0] next_addr_q;

  logic                       insn_fire;
  logic                       aw_fire;
  vst_pkg::bcnt_t             total_beats;
  vst_pkg::bcnt_t             src_beats;
  vst_pkg::bcnt_t             cur_beats;
  logic [`VST_AXI_ADDR_W-1:0] src_addr;

  // Two-entry burst FIFO toward the store unit
  logic [`VST_AXI_ADDR_W-1:0] fifo_addr_q [2];
  logic [7:0]                 fifo_len_q  [2];
  logic                       wr_pnt_q;
  logic                       rd_pnt_q;
  logic [1:0]                 fill_q;
  logic                       pop;

  // Only one instruction at a time, next one after its last AW
  assign insn.ready = !aw_pend_q;
  assign insn_fire  = insn.valid && insn.ready;

  // Round bytes up to whole AXI words
  assign total_beats = vst_pkg::bcnt_t'((32'(insn.byte_cnt) + AxiBytes - 1) >> AxiShift);

  // First burst comes from the instruction, later ones from the remainder
  assign src_beats = insn_fire ? total_beats : rem_q;
  assign src_addr  = insn_fire ? insn.req.addr : next_addr_q;
  assign cur_beats = (src_beats > vst_pkg::bcnt_t'(MaxBeats)) ?
                     vst_pkg::bcnt_t'(MaxBeats) : src_beats;

  // AW waits for a free FIFO slot, slots only free up meanwhile
  assign axi_aw_valid_o = aw_pend_q && (fill_q != 2'd2);
  assign aw_fire        = axi_aw_valid_o && axi_aw_ready_i;
  assign axi_aw_addr_o  = aw_addr_q;
  assign axi_aw_len_o   = aw_len_q;
  // Full-width beats, incrementing bursts
  assign axi_aw_size_o  = 3'(AxiShift);
  assign axi_aw_burst_o = 2'b01;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_pend_q   <= 1'b0;
      aw_addr_q   <= '0;
      aw_len_q    <= '0;
      rem_q       <= '0;
      next_addr_q <= '0;
    end else begin
      if (insn_fire || (aw_fire && rem_q != '0)) begin
        // Prepare the next burst, valid in the following cycle
        aw_pend_q   <= 1'b1;
        aw_addr_q   <= src_addr;
        aw_len_q    <= 8'(cur_beats - 1'b1);
        rem_q       <= src_beats - cur_beats;
        next_addr_q <= src_addr + `VST_AXI_ADDR_W'(cur_beats << AxiShift);
      end else if (aw_fire) begin
        // Last burst gone
        aw_pend_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Posted bursts

  assign burst.valid = fill_q != 2'd0;
  assign burst.addr  = fifo_addr_q[rd_pnt_q];
  assign burst.len   = fifo_len_q[rd_pnt_q];
  assign pop         = burst.valid && burst.ready;

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      fifo_addr_q[wr_pnt_q] <= aw_addr_q;
      fifo_len_q[wr_pnt_q]  <= aw_len_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= 1'b0;
      rd_pnt_q <= 1'b0;
      fill_q   <= 2'd0;
    end else begin
      if (aw_fire) wr_pnt_q <= !wr_pnt_q;
      if (pop) rd_pnt_q <= !rd_pnt_q;
      fill_q <= fill_q + 2'(aw_fire) - 2'(pop);
    end
  end

endmodule : vst_addrgen

// ==== logic/vst_store_unit.sv ====
`timescale 1ns/10ps
`include "vst_defines.svh"

module vst_store_unit (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Sequencer
  input  vst_pkg::st_req_t                              req_i,
  input  logic                                          req_valid_i,
  output logic                                          req_ready_o,
  output vst_pkg::st_resp_t                             resp_o,
  // Lanes
  input  logic [`VST_NR_LANES-1:0][`VST_ELEN-1:0]       operand_i,
  input  logic [`VST_NR_LANES-1:0]                      operand_valid_i,
  output logic                                          operand_ready_o,
  input  logic [`VST_NR_LANES-1:0][`VST_ELEN/8-1:0]     mask_i,
  input  logic [`VST_NR_LANES-1:0]                      mask_valid_i,
  output logic                                          mask_ready_o,
  // AXI W and B
  output logic [`VST_AXI_DATA_W-1:0]                    axi_w_data_o,
  output logic [`VST_AXI_DATA_W/8-1:0]                  axi_w_strb_o,
  output logic                                          axi_w_last_o,
  output logic                                          axi_w_valid_o,
  input  logic                                          axi_w_ready_i,
  input  logic                                          axi_b_valid_i,
  output logic                                          axi_b_ready_o,
  output logic                                          store_pending_o,
  // Address generator
  vst_insn_if.issuer                                    insn,
  vst_burst_if.sink                                     burst
);

  localparam int unsigned NrLanes    = `VST_NR_LANES;
  localparam int unsigned AxiBytes   = `VST_AXI_DATA_W / 8;
  localparam int unsigned AxiShift   = $clog2(AxiBytes);
  localparam int unsigned WordBytes  = NrLanes * `VST_ELEN / 8;
  localparam int unsigned Depth      = `VST_QUEUE_DEPTH;
  localparam int unsigned PntW       = $clog2(Depth);
  localparam int unsigned MaxBeats   = `VST_MAX_BEATS;
  localparam int unsigned BurstShift = $clog2(MaxBeats);

  function automatic vst_pkg::bcnt_t byte_cnt(vst_pkg::st_req_t r);
    return vst_pkg::bcnt_t'(r.vl) << r.vsew;
  endfunction

  // One B per AXI burst of the instruction
  function automatic vst_pkg::bcnt_t nr_bursts(vst_pkg::st_req_t r);
    logic [31:0] beats;
    beats = (32'(byte_cnt(r)) + AxiBytes - 1) >> AxiShift;
    return vst_pkg::bcnt_t'((beats + MaxBeats - 1) >> BurstShift);
  endfunction

  ////////////////////////////////////////////////////
  // Instruction queue

  vst_pkg::st_req_t [Depth-1:0] queue_q;
  logic [PntW-1:0]              accept_pnt_q;
  logic [PntW-1:0]              issue_pnt_q;
  logic [PntW-1:0]              commit_pnt_q;
  // Not yet fully issued / not yet retired
  logic [PntW:0]                issue_cnt_q;
  logic [PntW:0]                commit_cnt_q;
  logic [`VST_NR_VINSN-1:0]     running_d, running_q;

  logic                         queue_full;
  logic                         issue_valid;
  logic                         accept;
  vst_pkg::st_req_t             issue_req;
  vst_pkg::st_req_t             commit_req;
  vst_pkg::bcnt_t               issue_bytes;
  vst_pkg::st_resp_t            resp_d;

  assign queue_full  = commit_cnt_q == (PntW+1)'(Depth);
  assign issue_valid = issue_cnt_q != '0;
  // Ids still in flight are held off
  assign req_ready_o = !queue_full && !running_q[req_i.id];
  assign accept      = req_valid_i && req_ready_o;
  assign issue_req   = queue_q[issue_pnt_q];
  assign commit_req  = queue_q[commit_pnt_q];
  assign issue_bytes = byte_cnt(issue_req);

  always_ff @(posedge clk_i) begin
    if (accept) queue_q[accept_pnt_q] <= req_i;
  end

  // Handed to the address generator once per instruction
  logic insn_sent_q;

  assign insn.valid    = issue_valid && !insn_sent_q;
  assign insn.req      = issue_req;
  assign insn.byte_cnt = issue_bytes;

  ////////////////////////////////////////////////////
  // W beats

  // Bytes already sent of the issuing store
  vst_pkg::bcnt_t             seq_q;
  // Byte offset inside the current lane word
  logic [$clog2(WordBytes):0] vrf_pnt_q;
  // Beat inside the posted burst
  logic [7:0]                 beat_q;

  logic w_fire;
  logic insn_done;
  logic word_done;

  assign axi_w_valid_o = issue_valid && (&operand_valid_i) &&
                         (issue_req.vm || (&mask_valid_i)) && burst.valid;
  assign w_fire        = axi_w_valid_o && axi_w_ready_i;
  assign axi_w_last_o  = beat_q == burst.len;
  // Burst released with its last beat
  assign burst.ready   = w_fire && axi_w_last_o;

  assign insn_done = w_fire && (32'(seq_q) + AxiBytes >= 32'(issue_bytes));
  assign word_done = insn_done || (w_fire && (32'(vrf_pnt_q) + AxiBytes == WordBytes));

  assign operand_ready_o = word_done;
  assign mask_ready_o    = word_done && !issue_req.vm;

  // Lane deshuffle, element e sits in lane e mod NrLanes at slot e / NrLanes
  always_comb begin
    axi_w_data_o = '0;
    axi_w_strb_o = '0;
    for (int unsigned b = 0; b < AxiBytes; b++) begin
      automatic int unsigned s    = 32'(vrf_pnt_q) + b;
      automatic int unsigned elem = s >> issue_req.vsew;
      automatic int unsigned lane = elem % NrLanes;
      automatic int unsigned off  = ((elem / NrLanes) << issue_req.vsew) +
                                    (s & ((1 << issue_req.vsew) - 1));
      axi_w_data_o[8*b +: 8] = operand_i[lane][8*off +: 8];
      // Tail bytes stay off
      if (32'(seq_q) + b < 32'(issue_bytes))
        axi_w_strb_o[b] = issue_req.vm || mask_i[lane][off];
    end
  end

  ////////////////////////////////////////////////////
  // B channel and done reporting

  vst_pkg::bcnt_t b_cnt_q;
  logic           b_fire;
  logic           commit_done;

  assign store_pending_o = commit_cnt_q != '0;
  assign axi_b_ready_o   = store_pending_o;
  assign b_fire          = axi_b_valid_i && axi_b_ready_o;
  // Oldest store retires on the B of its last burst
  assign commit_done     = b_fire && (b_cnt_q + 1'b1 == nr_bursts(commit_req));

  always_comb begin
    running_d = running_q;
    resp_d    = '0;
    if (commit_done) begin
      running_d[commit_req.id]         = 1'b0;
      resp_d.vinsn_done[commit_req.id] = 1'b1;
    end
    if (accept) running_d[req_i.id] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      running_q    <= '0;
      insn_sent_q  <= 1'b0;
      seq_q        <= '0;
      vrf_pnt_q    <= '0;
      beat_q       <= '0;
      b_cnt_q      <= '0;
      resp_o       <= '0;
    end else begin
      if (accept) accept_pnt_q <= accept_pnt_q + 1'b1;
      if (insn.valid && insn.ready) insn_sent_q <= 1'b1;
      if (w_fire) begin
        seq_q     <= seq_q + vst_pkg::bcnt_t'(AxiBytes);
        vrf_pnt_q <= word_done ? '0 : vrf_pnt_q + ($clog2(WordBytes)+1)'(AxiBytes);
        beat_q    <= axi_w_last_o ? 8'd0 : beat_q + 8'd1;
      end
      // Last byte sent, next store takes the issue slot
      if (insn_done) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
        seq_q       <= '0;
        insn_sent_q <= 1'b0;
      end
      if (b_fire) b_cnt_q <= commit_done ? '0 : b_cnt_q + 1'b1;
      if (commit_done) commit_pnt_q <= commit_pnt_q + 1'b1;
      issue_cnt_q  <= issue_cnt_q + (PntW+1)'(accept) - (PntW+1)'(insn_done);
      commit_cnt_q <= commit_cnt_q + (PntW+1)'(accept) - (PntW+1)'(commit_done);
      running_q    <= running_d;
      resp_o       <= resp_d;
    end
  end

endmodule : vst_store_unit

// ==== logic/vst_top.sv ====
`timescale 1ns/10ps
`include "vst_defines.svh"

module vst_top (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Sequencer
  input  vst_pkg::st_req_t                          req_i,
  input  logic                                      req_valid_i,
  output logic                                      req_ready_o,
  output vst_pkg::st_resp_t                         resp_o,
  // Lanes and mask
  input  logic [`VST_NR_LANES-1:0][`VST_ELEN-1:0]   operand_i,
  input  logic [`VST_NR_LANES-1:0]                  operand_valid_i,
  output logic                                      operand_ready_o,
  input  logic [`VST_NR_LANES-1:0][`VST_ELEN/8-1:0] mask_i,
  input  logic [`VST_NR_LANES-1:0]                  mask_valid_i,
  output logic                                      mask_ready_o,
  // AXI AW
  output logic [`VST_AXI_ADDR_W-1:0]                axi_aw_addr_o,
  output logic [7:0]                                axi_aw_len_o,
  output logic [2:0]                                axi_aw_size_o,
  output logic [1:0]                                axi_aw_burst_o,
  output logic                                      axi_aw_valid_o,
  input  logic                                      axi_aw_ready_i,
  // AXI W
  output logic [`VST_AXI_DATA_W-1:0]                axi_w_data_o,
  output logic [`VST_AXI_DATA_W/8-1:0]              axi_w_strb_o,
  output logic                                      axi_w_last_o,
  output logic                                      axi_w_valid_o,
  input  logic                                      axi_w_ready_i,
  // AXI B
  input  logic                                      axi_b_valid_i,
  output logic                                      axi_b_ready_o,
  output logic                                      store_pending_o
);

  // Store unit to address generator
  vst_insn_if  insn_if ();
  // Address generator back to store unit
  vst_burst_if burst_if ();

  vst_addrgen i_addrgen (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn           (insn_if.taker),
    .burst          (burst_if.source),
    .axi_aw_addr_o  (axi_aw_addr_o),
    .axi_aw_len_o   (axi_aw_len_o),
    .axi_aw_size_o  (axi_aw_size_o),
    .axi_aw_burst_o (axi_aw_burst_o),
    .axi_aw_valid_o (axi_aw_valid_o),
    .axi_aw_ready_i (axi_aw_ready_i)
  );

  vst_store_unit i_store_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .resp_o          (resp_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .axi_w_data_o    (axi_w_data_o),
    .axi_w_strb_o    (axi_w_strb_o),
    .axi_w_last_o    (axi_w_last_o),
    .axi_w_valid_o   (axi_w_valid_o),
    .axi_w_ready_i   (axi_w_ready_i),
    .axi_b_valid_i   (axi_b_valid_i),
    .axi_b_ready_o   (axi_b_ready_o),
    .store_pending_o (store_pending_o),
    .insn            (insn_if.issuer),
    .burst           (burst_if.sink)
  );

endmodule : vst_top

// ==== testbench/vst_assertions.sv ====
`timescale 1ns/10ps
`include "vst_defines.svh"

module vst_assertions (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         req_ready_o,
  input logic                         store_pending_o,
  input logic                         axi_aw_valid_o,
  input logic                         axi_aw_ready_i,
  input logic [`VST_AXI_ADDR_W-1:0]   axi_aw_addr_o,
  input logic [7:0]                   axi_aw_len_o,
  input logic                         axi_w_valid_o,
  input logic                         axi_w_ready_i,
  input logic                         axi_w_last_o,
  input logic [`VST_AXI_DATA_W-1:0]   axi_w_data_o,
  input logic [`VST_AXI_DATA_W/8-1:0] axi_w_strb_o,
  input logic                         axi_b_ready_o
);

  // Burst lengths in AW order, popped by W last
  logic [7:0] len_fifo_q [4];
  logic [1:0] wr_pnt_q;
  logic [1:0] rd_pnt_q;
  logic [7:0] beat_q;

  always_ff @(posedge clk_i) begin
    if (axi_aw_valid_o && axi_aw_ready_i) len_fifo_q[wr_pnt_q] <= axi_aw_len_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      beat_q   <= '0;
    end else begin
      if (axi_aw_valid_o && axi_aw_ready_i) wr_pnt_q <= wr_pnt_q + 2'd1;
      if (axi_w_valid_o && axi_w_ready_i) begin
        if (axi_w_last_o) begin
          rd_pnt_q <= rd_pnt_q + 2'd1;
          beat_q   <= '0;
        end else begin
          beat_q <= beat_q + 8'd1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Reset state

  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !axi_aw_valid_o && !axi_w_valid_o && !axi_b_ready_o &&
                req_ready_o && !store_pending_o)
    else $error("outputs not idle during reset");

  //////////////////////////////////////////////////
  // Valid holds until ready

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_aw_valid_o && !axi_aw_ready_i |=>
      axi_aw_valid_o && $stable(axi_aw_addr_o) && $stable(axi_aw_len_o))
    else $error("AW dropped or changed before ready");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o && !axi_w_ready_i |=>
      axi_w_valid_o && $stable(axi_w_data_o) && $stable(axi_w_strb_o) &&
      $stable(axi_w_last_o))
    else $error("W dropped or changed before ready");

  // W last closes the burst after len plus one beats
  w_last_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o && axi_w_ready_i && axi_w_last_o |-> beat_q == len_fifo_q[rd_pnt_q])
    else $error("W last at wrong beat");

endmodule : vst_assertions

bind vst_top vst_assertions i_assertions (.*);

// ==== testbench/tb_vst_top.sv ====
`timescale 1ns/10ps
`include "vst_defines.svh"

module tb_vst_top;

  localparam int NrEnt   = 6;
  localparam int Timeout = 5000;

  logic                                      clk_i;
  logic                                      rst_ni;
  vst_pkg::st_req_t                          req;
  logic                                      req_valid;
  logic                                      req_ready;
  vst_pkg::st_resp_t                         resp;
  logic [`VST_NR_LANES-1:0][`VST_ELEN-1:0]   operand;
  logic [`VST_NR_LANES-1:0]                  operand_valid;
  logic                                      operand_ready;
  logic [`VST_NR_LANES-1:0][`VST_ELEN/8-1:0] mask;
  logic [`VST_NR_LANES-1:0]                  mask_valid;
  logic                                      mask_ready;
  logic [`VST_AXI_ADDR_W-1:0]                aw_addr;
  logic [7:0]                                aw_len;
  logic [2:0]                                aw_size;
  logic [1:0]                                aw_burst;
  logic                                      aw_valid;
  logic                                      aw_ready;
  logic [`VST_AXI_DATA_W-1:0]                w_data;
  logic [`VST_AXI_DATA_W/8-1:0]              w_strb;
  logic                                      w_last;
  logic                                      w_valid;
  logic                                      w_ready;
  logic                                      b_valid;
  logic                                      b_ready;
  logic                                      pending;

  // Stores: id, base, vl, log2 width, vm, mask pattern, expected bursts
  int          tab_id     [NrEnt] = '{0, 1, 2, 3, 4, 5};
  int          tab_addr   [NrEnt] = '{'h1000, 'h2000, 'h3000, 'h4000, 'h5000, 'h6000};
  int          tab_vl     [NrEnt] = '{40, 10, 5, 12, 20, 3};
  int          tab_sew    [NrEnt] = '{0, 3, 1, 2, 0, 3};
  int          tab_vm     [NrEnt] = '{1, 1, 1, 0, 0, 1};
  logic [31:0] tab_mask   [NrEnt] = '{0, 0, 0, 32'h0000_0a5b, 32'h00f3_c96e, 0};
  int          tab_bursts [NrEnt] = '{2, 3, 1, 2, 1, 1};

  integer     seed;
  int         errors;
  int         checks;
  int         tests;
  logic       active;
  logic       rnd;
  logic [7:0] mem [int];
  int         aw_addr_q [$];
  int         aw_len_q [$];
  int         done_q [$];
  int         w_beat;
  int         b_pend;
  int         aw_count;
  int         lane_k;
  int         lane_g;
  logic       lane_adv;
  logic       b_fire;
  logic       saw_full;

  vst_top uut (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .req_i (req), .req_valid_i (req_valid), .req_ready_o (req_ready), .resp_o (resp),
    .operand_i (operand), .operand_valid_i (operand_valid), .operand_ready_o (operand_ready),
    .mask_i (mask), .mask_valid_i (mask_valid), .mask_ready_o (mask_ready),
    .axi_aw_addr_o (aw_addr), .axi_aw_len_o (aw_len), .axi_aw_size_o (aw_size),
    .axi_aw_burst_o (aw_burst), .axi_aw_valid_o (aw_valid), .axi_aw_ready_i (aw_ready),
    .axi_w_data_o (w_data), .axi_w_strb_o (w_strb), .axi_w_last_o (w_last),
    .axi_w_valid_o (w_valid), .axi_w_ready_i (w_ready),
    .axi_b_valid_i (b_valid), .axi_b_ready_o (b_ready), .store_pending_o (pending)
  );

  always #50 clk_i = ~clk_i;

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic give_up(input string why);
    $display("Timeout: %s", why);
    $display("TEST FAIL");
    $finish;
  endtask

  // Three in four cycles under back-pressure
  function logic chance();
    chance = ($random(seed) & 3) != 0;
  endfunction

  // Untouched memory, every address bit takes part
  function automatic logic [7:0] fill(int a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [7:0] elem_byte(int k, int e, int i);
    return 8'((k * 256 + e) >> (8 * i));
  endfunction

  function automatic logic elem_on(int k, int e);
    return tab_vm[k] != 0 || tab_mask[k][e % 32];
  endfunction

  // Lane l of word group g, element 2j+l at slot j
  function automatic logic [63:0] lane_word(int k, int g, int l);
    logic [63:0] w;
    int          wb;
    w  = '0;
    wb = 1 << tab_sew[k];
    for (int j = 0; j < 8 / wb; j++)
      for (int i = 0; i < wb; i++)
        w[8*(j*wb+i) +: 8] = elem_byte(k, g * (16 / wb) + 2 * j + l, i);
    return w;
  endfunction

  function automatic logic [7:0] mask_word(int k, int g, int l);
    logic [7:0] m;
    int         wb;
    m  = '0;
    wb = 1 << tab_sew[k];
    for (int j = 0; j < 8 / wb; j++)
      for (int i = 0; i < wb; i++)
        m[j*wb+i] = elem_on(k, g * (16 / wb) + 2 * j + l);
    return m;
  endfunction

  //////////////////////////////////////////////////
  // Lane, memory and B models

  always @(posedge clk_i) begin
    if (active) begin
      lane_adv = operand_valid[0] && operand_ready;
      b_fire   = b_valid && b_ready;
      // Only masked stores take the mask along with the lane word
      if (lane_adv)
        check_value("mask ready with lane word", mask_ready, tab_vm[lane_k] == 0);
      else
        check_value("mask ready while idle", mask_ready, 0);
      if (aw_valid && aw_ready) begin
        check_value("AW len within max burst", aw_len < `VST_MAX_BEATS, 1);
        // Full-width beats of an INCR burst
        check_value("AW size", aw_size, $clog2(`VST_AXI_DATA_W / 8));
        check_value("AW burst type", aw_burst, 2'b01);
        aw_addr_q.push_back(aw_addr);
        aw_len_q.push_back(aw_len);
        aw_count++;
      end
      if (w_valid && w_ready) begin
        if (aw_addr_q.size() == 0) begin
          errors++;
          $display("W beat seen without an open AW burst at %0t", $time);
        end else begin
          for (int b = 0; b < 8; b++)
            if (w_strb[b]) mem[aw_addr_q[0] + 8 * w_beat + b] = w_data[8*b +: 8];
          if (w_last) begin
            check_value("beats per burst", w_beat, aw_len_q[0]);
            void'(aw_addr_q.pop_front());
            void'(aw_len_q.pop_front());
            w_beat = 0;
            b_pend++;
          end else begin
            w_beat++;
          end
        end
      end
      if (b_fire) b_pend--;
      if (lane_adv) begin
        lane_g++;
        if (lane_g == ((tab_vl[lane_k] << tab_sew[lane_k]) + 15) / 16) begin
          lane_k++;
          lane_g = 0;
        end
      end
      for (int i = 0; i < `VST_NR_VINSN; i++)
        if (resp.vinsn_done[i]) done_q.push_back(i);
      if (req_valid && !req_ready && pending) saw_full = 1'b1;
      #1;
      aw_ready = rnd ? chance() : 1'b1;
      w_ready  = rnd ? chance() : 1'b1;
      if (b_fire) b_valid = 1'b0;
      if (!b_valid && b_pend > 0) b_valid = rnd ? chance() : 1'b1;
      if (lane_k < NrEnt) begin
        if (lane_adv || !operand_valid[0]) operand_valid = (rnd && !chance()) ? '0 : '1;
        for (int l = 0; l < `VST_NR_LANES; l++) begin
          operand[l] = lane_word(lane_k, lane_g, l);
          mask[l]    = mask_word(lane_k, lane_g, l);
        end
      end else begin
        operand_valid = '0;
      end
      mask_valid = operand_valid;
    end
  end

  //////////////////////////////////////////////////
  // Sequencer and checks

  task automatic send_request(input int k);
    int t;
    req.id    = vst_pkg::vinsn_id_t'(tab_id[k]);
    req.addr  = tab_addr[k];
    req.vl    = vst_pkg::vl_t'(tab_vl[k]);
    req.vsew  = vst_pkg::vew_e'(tab_sew[k]);
    req.vm    = tab_vm[k] != 0;
    req_valid = 1'b1;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
      if (t > Timeout) give_up("request not accepted");
    end while (!req_ready);
    #1;
  endtask

  task automatic check_memory(input int phase, input int k);
    int   first_err;
    int   bytes;
    int   wb;
    int   off;
    logic [7:0] exp;
    first_err = errors;
    wb        = 1 << tab_sew[k];
    bytes     = tab_vl[k] * wb;
    // Guard bytes on both sides stay at the fill value
    for (int a = tab_addr[k] - 16; a < tab_addr[k] + bytes + 16; a++) begin
      off = a - tab_addr[k];
      exp = fill(a);
      if (off >= 0 && off < bytes && elem_on(k, off / wb)) exp = elem_byte(k, off / wb, off % wb);
      check_value($sformatf("mem byte %0h", a), mem.exists(a) ? mem[a] : fill(a), exp);
    end
    tests++;
    $display("phase %0d store %0d (id %0d): %s", phase, k, tab_id[k],
             errors == first_err ? "ok" : "mismatch");
  endtask

  task automatic run_phase(input int phase);
    int t;
    int first_err;
    // Let the models close the last cycle of the previous phase
    if (phase > 0) #20;
    active        = 1'b0;
    rnd           = phase == 1;
    rst_ni        = 1'b0;
    req           = '0;
    req_valid     = 1'b0;
    operand       = '0;
    operand_valid = '0;
    mask          = '0;
    mask_valid    = '0;
    aw_ready      = 1'b0;
    w_ready       = 1'b0;
    b_valid       = 1'b0;
    mem.delete();
    aw_addr_q.delete();
    aw_len_q.delete();
    done_q.delete();
    w_beat   = 0;
    b_pend   = 0;
    aw_count = 0;
    lane_k   = 0;
    lane_g   = 0;
    saw_full = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    active = 1'b1;
    for (int k = 0; k < NrEnt; k++) send_request(k);
    req_valid = 1'b0;
    t = 0;
    while (done_q.size() < NrEnt) begin
      @(posedge clk_i);
      t++;
      if (t > Timeout) give_up("stores never completed");
    end
    first_err = errors;
    for (int k = 0; k < NrEnt; k++) check_value("done order", done_q[k], tab_id[k]);
    check_value("request ready dropped on full queue", saw_full, 1);
    check_value("store pending after last B", pending, 0);
    t = 0;
    for (int k = 0; k < NrEnt; k++) t += tab_bursts[k];
    check_value("AW burst count", aw_count, t);
    tests++;
    $display("phase %0d queue and done: %s", phase, errors == first_err ? "ok" : "mismatch");
    for (int k = 0; k < NrEnt; k++) check_memory(phase, k);
  endtask

  initial begin
    seed   = 32'hd50d_4117;
    errors = 0;
    checks = 0;
    tests  = 0;
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    active = 1'b0;
    rnd    = 1'b0;
    // Phase 0 runs at full speed, phase 1 under random back-pressure
    for (int phase = 0; phase < 2; phase++) run_phase(phase);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_vst_top

// ==== files.f ====
+incdir+logic
logic/vst_pkg.sv
logic/vst_insn_if.sv
logic/vst_burst_if.sv
logic/vst_addrgen.sv
logic/vst_store_unit.sv
logic/vst_top.sv
testbench/vst_assertions.sv
testbench/tb_vst_top.sv

// ==== Bender.yml ====
package:
  name: vst

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/vst_pkg.sv
      - logic/vst_insn_if.sv
      - logic/vst_burst_if.sv
      - logic/vst_addrgen.sv
      - logic/vst_store_unit.sv
      - logic/vst_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/vst_assertions.sv
      - testbench/tb_vst_top.sv
